// ==== src/fabric_defs.svh ====
// board widths and timing constants for the fabric-side logic
// include after the timescale line; the guard makes repeat includes harmless
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// ======================================================================
// port widths
// ======================================================================
`define KEY_W  2            // push buttons
`define SW_W   4            // slide switches
`define LED_W  8            // board leds, bit 0 is the heartbeat
`define STM_W  28           // trace-event word toward the processor

// ======================================================================
// timing, in fpga_clk_50 cycles
// ======================================================================
`define DEBOUNCE_CYCLES        50000      // 1 ms settle at 50 MHz
`define HEARTBEAT_HALF_PERIOD  25000000   // 0.5 s on, 0.5 s off

// reset-request pulse lengths
`define COLD_PULSE_EXT   6
`define WARM_PULSE_EXT   2
`define DEBUG_PULSE_EXT  32

`endif

// ==== src/hps_fabric_pkg.sv ====
// packed types shared by the fabric RTL and its testbench
// import with a wildcard inside a module, or use scoped names in port lists
`default_nettype none

`include "fabric_defs.svh"

package hps_fabric_pkg;

  // ======================================================================
  // plain vectors
  // ======================================================================
  typedef logic [`KEY_W-1:0]   key_t;          // active low, 0 = pressed
  typedef logic [`SW_W-1:0]    sw_t;
  typedef logic [`LED_W-2:0]   fabric_led_t;   // leds 7..1, written by the processor
  typedef logic [`LED_W-1:0]   led_t;

  // ======================================================================
  // structs
  // ======================================================================
  // one flag per reset kind, used for request levels and output pulses
  // bit order follows the old source/probe vector: [0] cold, [1] warm, [2] debug
  typedef struct packed {
    logic debug;
    logic warm;
    logic cold;
  } reset_req_t;

  // stm hardware event word, msb first
  typedef struct packed {
    logic [`STM_W-`SW_W-`LED_W-`KEY_W:0] pad;   // 15 bits, always zero
    sw_t                                 sw;
    fabric_led_t                         fabric_led;
    key_t                                buttons;  // debounced keys
  } stm_events_t;

  // pulse controller states
  typedef enum logic {
    idle    = 1'b0,   // waiting for a rising request edge
    stretch = 1'b1    // pulse running, new edges ignored
  } pulse_state_t;

endpackage

`default_nettype wire

// ==== src/cycle_timer.sv ====
// modulo-N cycle counter with a one-cycle strobe on the last count
// hold restart high to park it at zero; shared by debounce, heartbeat and pulses
`timescale 1ns/1ps
`default_nettype none

module cycle_timer #(
  parameter int cycles = 16                   // period in clock cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic restart,                       // clears count at next edge
  output logic expire                         // high on count == cycles-1
);

  // at least one bit, even for a period of 1
  localparam int               cnt_w = (cycles > 1) ? $clog2(cycles) : 1;
  localparam logic [cnt_w-1:0] last  = cnt_w'(cycles - 1);

  logic [cnt_w-1:0] count;
  logic             at_last;

  assign at_last = (count == last);

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      count <= '0;
    end
    else if (restart || at_last)              // park, or wrap after N cycles
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // restart wins over a pending expiry
  assign expire = at_last && !restart;

endmodule

`default_nettype wire

// ==== src/key_debounce.sv ====
// push-button conditioning: two-flop synchronizer, then one settle timer per key
// a level must hold for debounce_cycles before it reaches buttons
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module key_debounce #(
  parameter int debounce_cycles = `DEBOUNCE_CYCLES
) (
  input  logic                 fpga_clk_50,
  input  logic                 hps_fpga_reset_n,
  input  hps_fabric_pkg::key_t key,           // raw pins, async to the clock
  output hps_fabric_pkg::key_t buttons        // debounced, active low
);

  import hps_fabric_pkg::*;

  key_t              key_meta;                // first sync stage
  key_t              key_sync;                // second sync stage
  logic [`KEY_W-1:0] settle_restart;
  logic [`KEY_W-1:0] settle_done;

  // ======================================================================
  // synchronizer
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;                         // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ======================================================================
  // settle timers
  // ======================================================================
  for (genvar i = 0; i < `KEY_W; i++)
  begin : g_settle
    // timer runs only while the pin disagrees with the held level
    assign settle_restart[i] = (key_sync[i] == buttons[i]);

    cycle_timer #(
      .cycles           (debounce_cycles)
    ) u_settle_timer (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .restart          (settle_restart[i]),
      .expire           (settle_done[i])
    );
  end

  // debounced level, updated per bit when its timer runs out
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      buttons <= '1;                          // all released
    end
    else
    begin
      for (int b = 0; b < `KEY_W; b++)
      begin
        if (settle_done[b])
          buttons[b] <= key_sync[b];          // new level has held long enough
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/heartbeat_blinker.sv ====
// heartbeat for led 0: square wave with period 2*half_period
// low out of reset, first toggle half_period edges after release
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module heartbeat_blinker #(
  parameter int half_period = `HEARTBEAT_HALF_PERIOD
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic beat
);

  logic half_done;

  // free running, never restarted
  cycle_timer #(
    .cycles           (half_period)
  ) u_half_timer (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .restart          (1'b0),
    .expire           (half_done)
  );

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      beat <= 1'b0;
    else if (half_done)
      beat <= ~beat;                          // flip every half period
  end

endmodule

`default_nettype wire

// ==== src/reset_pulse_ctrl.sv ====
// turns the rising edge of a request level into one pulse of pulse_ext cycles
// pulse starts two edges after the request rises; edges during a pulse are dropped
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_ctrl #(
  parameter int pulse_ext = 2                 // pulse length in cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,                       // level, synchronous
  output logic pulse                          // active high
);

  import hps_fabric_pkg::*;

  pulse_state_t state;
  logic         req_q;                        // registered request
  logic         req_qq;                       // one cycle older, for edge detect
  logic         req_rise;
  logic         timer_restart;
  logic         stretch_done;

  // ======================================================================
  // request edge detect
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q  <= 1'b0;
      req_qq <= 1'b0;
    end
    else
    begin
      req_q  <= request;
      req_qq <= req_q;
    end
  end

  assign req_rise = req_q && !req_qq;         // one cycle per rising edge

  // ======================================================================
  // idle / stretch fsm
  // ======================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= idle;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (req_rise)
            state <= stretch;
        end
        stretch:
        begin
          if (stretch_done)                   // last pulse cycle
            state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // timer parked at zero in idle, so each stretch counts a full period
  assign timer_restart = (state == idle);

  cycle_timer #(
    .cycles           (pulse_ext)
  ) u_stretch_timer (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .restart          (timer_restart),
    .expire           (stretch_done)
  );

  assign pulse = (state == stretch);

endmodule

`default_nettype wire

// ==== src/hps_fabric_top.sv ====
// fabric-side glue around the processor: key debounce, heartbeat led,
// reset-request pulse stretchers and the stm trace-event word
// all logic runs on fpga_clk_50 and is reset by hps_fpga_reset_n
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module hps_fabric_top #(
  parameter int debounce_cycles       = `DEBOUNCE_CYCLES,
  parameter int heartbeat_half_period = `HEARTBEAT_HALF_PERIOD
) (
  input  logic                        fpga_clk_50,
  input  logic                        hps_fpga_reset_n,   // from the processor

  input  hps_fabric_pkg::key_t        key,                // raw buttons, async
  input  hps_fabric_pkg::sw_t         sw,
  input  hps_fabric_pkg::fabric_led_t fabric_led,         // processor led register
  input  hps_fabric_pkg::reset_req_t  reset_req,          // request levels

  output hps_fabric_pkg::led_t        led,
  output hps_fabric_pkg::key_t        buttons,            // debounced, to the processor
  output hps_fabric_pkg::reset_req_t  reset_pulse,        // active high pulses
  output hps_fabric_pkg::stm_events_t stm_hw_events
);

  logic heartbeat;
  logic cold_pulse;
  logic warm_pulse;
  logic debug_pulse;

  // ======================================================================
  // buttons and leds
  // ======================================================================
  key_debounce #(
    .debounce_cycles  (debounce_cycles)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .buttons          (buttons)
  );

  heartbeat_blinker #(
    .half_period      (heartbeat_half_period)
  ) u_heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .beat             (heartbeat)
  );

  assign led = {fabric_led, heartbeat};       // 7..1 straight from the processor

  // ======================================================================
  // reset-request pulses
  // ======================================================================
  reset_pulse_ctrl #(
    .pulse_ext        (`COLD_PULSE_EXT)
  ) u_cold_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.cold),
    .pulse            (cold_pulse)
  );

  reset_pulse_ctrl #(
    .pulse_ext        (`WARM_PULSE_EXT)
  ) u_warm_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.warm),
    .pulse            (warm_pulse)
  );

  reset_pulse_ctrl #(
    .pulse_ext        (`DEBUG_PULSE_EXT)
  ) u_debug_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.debug),
    .pulse            (debug_pulse)
  );

  assign reset_pulse = '{debug: debug_pulse, warm: warm_pulse, cold: cold_pulse};

  // trace-event word, pure wiring
  assign stm_hw_events = '{
    pad:        '0,
    sw:         sw,
    fabric_led: fabric_led,
    buttons:    buttons
  };

endmodule

`default_nettype wire

// ==== verification/tb_hps_fabric_top.sv ====
// trace-driven testbench for the fabric glue that replays verification/fabric_trace.txt
// and checks every cycle against a reference built from the timing rules
// run from the project root so the trace path resolves
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module tb_hps_fabric_top;

  import hps_fabric_pkg::*;

  localparam int debounce_n  = 16;            // short settle for simulation
  localparam int half_period = 40;            // short heartbeat

  // one parsed trace line without its op keyword
  typedef struct packed {
    key_t        key;
    sw_t         sw;
    fabric_led_t fled;
    reset_req_t  req;
    logic [15:0] hold_cycles;
    key_t        exp_buttons;                 // expected at end of line
    reset_req_t  exp_pulse;
  } trace_row_t;

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  key_t        key;
  sw_t         sw;
  fabric_led_t fabric_led;
  reset_req_t  reset_req;
  led_t        led;
  key_t        buttons;
  reset_req_t  reset_pulse;
  stm_events_t stm_hw_events;

  // values for the next edge and values applied now
  key_t        next_key;
  sw_t         next_sw;
  fabric_led_t next_fled;
  reset_req_t  next_req;
  key_t        cur_key;
  sw_t         cur_sw;
  fabric_led_t cur_fled;
  reset_req_t  cur_req;

  // reference state
  int          edge_cnt;                      // edges since reset release
  key_t        ref_btn;                       // settled debounced level
  int          chg_edge [`KEY_W];             // edge of the last key change per bit
  int          pulse_start [3];               // [0] cold, [1] warm, [2] debug
  int          pulse_end [3];
  int          pulse_len [3];

  trace_row_t  rows[$];
  string       ops[$];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;               // 0 until the trace is loaded

  hps_fabric_top #(
    .debounce_cycles       (debounce_n),
    .heartbeat_half_period (half_period)
  ) u_hps_fabric_top (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .sw               (sw),
    .fabric_led       (fabric_led),
    .reset_req        (reset_req),
    .led              (led),
    .buttons          (buttons),
    .reset_pulse      (reset_pulse),
    .stm_hw_events    (stm_hw_events)
  );

  // ======================================================================
  // clock and watchdog
  // ======================================================================
  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #4 fpga_clk_50 = ~fpga_clk_50;    // 8 ns period
  end

  always @(posedge fpga_clk_50)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      report_failure($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
  end

  // ======================================================================
  // reporting and compare tasks
  // ======================================================================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_buttons(input key_t got, input key_t exp, input string ctx);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0d ns: %s, buttons %b expected %b",
                               $time, ctx, got, exp));
  endtask

  task automatic check_led(input led_t got, input led_t exp, input string ctx);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0d ns: %s, led %b expected %b",
                               $time, ctx, got, exp));
  endtask

  task automatic check_pulse(input reset_req_t got, input reset_req_t exp, input string ctx);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0d ns: %s, reset_pulse %b expected %b",
                               $time, ctx, got, exp));
  endtask

  task automatic check_events(input stm_events_t got, input stm_events_t exp,
                              input string ctx);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0d ns: %s, stm_hw_events %h expected %h",
                               $time, ctx, got, exp));
  endtask

  // ======================================================================
  // one clock cycle that drives at the rising edge and checks at the falling edge
  // ======================================================================
  task automatic step_cycle(input string ctx);
    logic [2:0]  old_req;
    logic [2:0]  new_req;
    logic [2:0]  exp_bits;
    key_t        exp_btn;
    logic        beat_ref;
    stm_events_t exp_ev;
    int          age;
    int          b;
    @(posedge fpga_clk_50);
    key        <= next_key;
    sw         <= next_sw;
    fabric_led <= next_fled;
    reset_req  <= next_req;
    edge_cnt = edge_cnt + 1;
    for (b = 0; b < `KEY_W; b++)
    begin
      if (next_key[b] != cur_key[b])
        chg_edge[b] = edge_cnt;               // settle window restarts
    end
    old_req = cur_req;
    new_req = next_req;
    for (b = 0; b < 3; b++)
    begin
      // rise acts only if the fsm is idle one edge later
      if (new_req[b] && !old_req[b] && (edge_cnt + 1 >= pulse_end[b]))
      begin
        pulse_start[b] = edge_cnt + 2;
        pulse_end[b]   = edge_cnt + 2 + pulse_len[b];
      end
    end
    cur_key  = next_key;
    cur_sw   = next_sw;
    cur_fled = next_fled;
    cur_req  = next_req;

    @(negedge fpga_clk_50);
    exp_btn = ref_btn;
    for (b = 0; b < `KEY_W; b++)
    begin
      if (cur_key[b] != ref_btn[b])
      begin
        age = edge_cnt - chg_edge[b];
        if (age >= debounce_n + 3)            // must have landed by now
        begin
          ref_btn[b] = cur_key[b];
          exp_btn[b] = cur_key[b];
        end
        else if (age >= debounce_n + 2)       // landing edge accepts either level
          exp_btn[b] = (buttons[b] === cur_key[b]) ? cur_key[b] : ref_btn[b];
      end
    end
    for (b = 0; b < 3; b++)
      exp_bits[b] = (edge_cnt >= pulse_start[b]) && (edge_cnt < pulse_end[b]);
    beat_ref = ((edge_cnt / half_period) % 2) == 1;   // toggles at edges N, 2N and so on
    exp_ev.pad        = '0;
    exp_ev.sw         = cur_sw;
    exp_ev.fabric_led = cur_fled;
    exp_ev.buttons    = exp_btn;
    check_buttons(buttons, exp_btn, ctx);
    check_led(led, {cur_fled, beat_ref}, ctx);
    check_pulse(reset_pulse, reset_req_t'(exp_bits), ctx);
    check_events(stm_hw_events, exp_ev, ctx);
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================
  initial
  begin
    int          fd;
    int          rc;
    int          n;
    int          idx;
    int          g;
    int          hold_sum;
    int          toggles;
    int          exp_toggles;
    logic        last_beat;
    string       line;
    string       op;
    string       ctx;
    logic [31:0] v_key;
    logic [31:0] v_sw;
    logic [31:0] v_fled;
    logic [31:0] v_req;
    logic [31:0] v_eb;
    logic [31:0] v_ep;
    int          v_hold;
    key_t        prev_key;
    trace_row_t  row;
    stm_events_t exp_ev;

    void'($urandom(47));                      // seed for the glitch lengths
    hps_fpga_reset_n = 1'b0;
    key        = '1;                          // released
    sw         = '0;
    fabric_led = '0;
    reset_req  = '0;
    next_key  = '1;
    next_sw   = '0;
    next_fled = '0;
    next_req  = '0;
    cur_key   = '1;
    cur_sw    = '0;
    cur_fled  = '0;
    cur_req   = '0;
    ref_btn   = '1;
    edge_cnt  = 0;
    for (idx = 0; idx < `KEY_W; idx++)
      chg_edge[idx] = 0;
    for (idx = 0; idx < 3; idx++)
    begin
      pulse_start[idx] = 0;
      pulse_end[idx]   = 0;
    end
    pulse_len[0] = `COLD_PULSE_EXT;
    pulse_len[1] = `WARM_PULSE_EXT;
    pulse_len[2] = `DEBUG_PULSE_EXT;

    // load the whole trace before time moves
    fd = $fopen("verification/fabric_trace.txt", "r");
    if (fd == 0)
      report_failure("could not open the trace file verification/fabric_trace.txt");
    hold_sum = 0;
    while (!$feof(fd))
    begin
      line = "";
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line[0] == "#")
        continue;                             // blank or comment
      n = $sscanf(line, "%s %h %h %h %h %d %h %h",
                  op, v_key, v_sw, v_fled, v_req, v_hold, v_eb, v_ep);
      if (n != 8)
        report_failure($sformatf("trace line could not be parsed: %s", line));
      row.key         = v_key[`KEY_W-1:0];
      row.sw          = v_sw[`SW_W-1:0];
      row.fled        = v_fled[`LED_W-2:0];
      row.req         = v_req[2:0];
      row.hold_cycles = v_hold[15:0];
      row.exp_buttons = v_eb[`KEY_W-1:0];
      row.exp_pulse   = v_ep[2:0];
      rows.push_back(row);
      ops.push_back(op);
      hold_sum = hold_sum + v_hold;
    end
    $fclose(fd);
    cycle_limit = 2 * hold_sum + 200;

    // reset over two edges and released at the second
    repeat (2) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    @(negedge fpga_clk_50);
    exp_ev.pad        = '0;
    exp_ev.sw         = cur_sw;
    exp_ev.fabric_led = cur_fled;
    exp_ev.buttons    = '1;
    check_buttons(buttons, '1, "after reset");
    check_led(led, {cur_fled, 1'b0}, "after reset");
    check_pulse(reset_pulse, '0, "after reset");
    check_events(stm_hw_events, exp_ev, "after reset");

    for (idx = 0; idx < rows.size(); idx++)
    begin
      row = rows[idx];
      ctx = $sformatf("trace line %0d (%s)", idx + 1, ops[idx]);
      next_key  = row.key;
      next_sw   = row.sw;
      next_fled = row.fled;
      next_req  = row.req;
      if (ops[idx] == "hold")
      begin
        repeat (row.hold_cycles) step_cycle(ctx);
      end
      else if (ops[idx] == "glitch")
      begin
        if (row.hold_cycles < 16)
          report_failure($sformatf("%s is too short for a glitch", ctx));
        prev_key = cur_key;
        g = 1 + int'($urandom % 15);          // 1 to 15 cycles stays below the settle time
        repeat (g) step_cycle(ctx);
        next_key = prev_key;                  // bounce back
        repeat (row.hold_cycles - g) step_cycle(ctx);
      end
      else if (ops[idx] == "beat")
      begin
        toggles   = 0;
        last_beat = led[0];
        repeat (row.hold_cycles)
        begin
          step_cycle(ctx);
          if (led[0] != last_beat)
            toggles++;
          last_beat = led[0];
        end
        exp_toggles = row.hold_cycles / half_period;
        if (toggles < exp_toggles - 1 || toggles > exp_toggles + 1)
          report_failure($sformatf(
            "mismatch at %0d ns: %s, heartbeat toggled %0d times, expected %0d",
            $time, ctx, toggles, exp_toggles));
      end
      else
      begin
        report_failure($sformatf("unknown operation in %s", ctx));
      end

      // trace columns at the end of the line
      exp_ev.pad        = '0;
      exp_ev.sw         = cur_sw;
      exp_ev.fabric_led = cur_fled;
      exp_ev.buttons    = row.exp_buttons;
      check_buttons(buttons, row.exp_buttons, {ctx, " end"});
      check_pulse(reset_pulse, row.exp_pulse, {ctx, " end"});
      check_events(stm_hw_events, exp_ev, {ctx, " end"});
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/hps_fabric_pkg.sv
src/cycle_timer.sv
src/key_debounce.sv
src/heartbeat_blinker.sv
src/reset_pulse_ctrl.sv
src/hps_fabric_top.sv
verification/tb_hps_fabric_top.sv

// ==== verification/fabric_trace.txt ====
# op key sw fled req hold exp_buttons exp_pulse (hold decimal, the rest hex)
# req and exp_pulse bits: [0] cold, [1] warm, [2] debug; key and buttons active low
hold   3 0 00 0   8 3 0
hold   2 5 2a 0  20 2 0
hold   3 5 2a 0  20 3 0
glitch 1 a 15 0  40 3 0
glitch 0 a 15 0  40 3 0
hold   0 c 7f 0  20 0 0
glitch 3 c 7f 0  40 0 0
hold   3 3 01 0  20 3 0
beat   3 3 55 0 200 3 0
hold   3 3 55 1   4 3 1
hold   3 3 55 0   8 3 0
hold   3 3 55 2   3 3 2
hold   3 3 55 0   8 3 0
hold   3 9 55 4  10 3 4
hold   3 9 55 0   4 3 4
hold   3 9 55 4  10 3 4
hold   3 9 55 4  20 3 0
hold   3 9 55 0   4 3 0
hold   3 9 55 4   6 3 4
hold   3 9 55 0  40 3 0
hold   3 6 2a 7   4 3 7
hold   3 6 2a 0  40 3 0
